// File: design/periph_defines.svh
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus widths
`define PERI_ADDR_W 11
`define PERI_DATA_W 32
`define PERI_OFS_W 6

// User slot numbers
`define PERI_SLOT_GPIO 1
// UART slot is not populated here, only used as a pin select reset code
`define PERI_SLOT_UART 2

// GPIO slot register offsets
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN 6'h04
// Pin i function select sits at base + 4*i
`define GPIO_OFS_FUNC_BASE 6'h20

// Number of output pins
`define PIN_COUNT 8

`endif

// File: design/periph_pkg.sv
`include "periph_defines.svh"

package periph_pkg;

    // Bus address and data words
    typedef logic [`PERI_ADDR_W-1:0] addr_t;
    typedef logic [`PERI_DATA_W-1:0] data_t;

    // Pin and GPIO data byte
    typedef logic [`PIN_COUNT-1:0] byte_t;

    // Register offset inside one 64-byte user slot
    typedef logic [`PERI_OFS_W-1:0] slot_ofs_t;

    // Pin function code
    // Bit 4 picks the byte window, bits 3:0 the slot number
    typedef logic [4:0] func_sel_t;

    // Request size code from the core, SZ_NONE means idle
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2,
        SZ_NONE = 2'd3
    } acc_size_e;

endpackage

// File: design/periph_slot_if.sv
`timescale 1ns/1ps

interface periph_slot_if;

    import periph_pkg::*;

    // Register offset within the slot
    slot_ofs_t ofs;

    // Low byte of the write data, only the low byte is ever stored
    byte_t     wdata;

    // Write strobe, already gated by the slot decode
    logic      wr;

    // Combinational read data, zero off the slot's registers
    data_t     rdata;

    // Bus controller side
    modport ctrl (
        output ofs,
        output wdata,
        output wr,
        input  rdata
    );

    // Register slot side
    modport slot (
        input  ofs,
        input  wdata,
        input  wr,
        output rdata
    );

endinterface

// File: design/gpio_out_reg.sv
`timescale 1ns/1ps
`include "periph_defines.svh"

module gpio_out_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::byte_t i_ui_in,
    periph_slot_if.slot       bus,
    output periph_pkg::byte_t o_gpio_out
);

    import periph_pkg::*;

    byte_t gpio_q;
    logic  out_hit;
    logic  in_hit;

    // Register decode inside the slot
    assign out_hit = (bus.ofs == slot_ofs_t'(`GPIO_OFS_OUT));
    assign in_hit  = (bus.ofs == slot_ofs_t'(`GPIO_OFS_IN));

    // Output byte register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_q <= '0;
        end else if (bus.wr && out_hit) begin
            gpio_q <= bus.wdata;
        end
    end

    assign o_gpio_out = gpio_q;

    // Readback of the output byte and the raw input pins
    always_comb begin
        if (out_hit) begin
            bus.rdata = data_t'(gpio_q);
        end else if (in_hit) begin
            bus.rdata = data_t'(i_ui_in);
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

// File: design/pin_func_mux.sv
`timescale 1ns/1ps
`include "periph_defines.svh"

module pin_func_mux (
    input  logic              clk,
    input  logic              rst_n,
    periph_slot_if.slot       bus,
    input  periph_pkg::byte_t i_gpio_out,
    output periph_pkg::byte_t o_uo_out
);

    import periph_pkg::*;

    localparam int PIN_IDX_W = $clog2(`PIN_COUNT);

    func_sel_t             func_q [`PIN_COUNT];
    slot_ofs_t             func_rel;
    logic [PIN_IDX_W-1:0]  func_idx;
    logic                  func_hit;

    // Offset relative to the first select register
    assign func_rel = bus.ofs - slot_ofs_t'(`GPIO_OFS_FUNC_BASE);

    // Word aligned offsets from the base up to the slot end
    assign func_hit = (bus.ofs >= slot_ofs_t'(`GPIO_OFS_FUNC_BASE)) &&
                      (func_rel[1:0] == 2'b00);
    assign func_idx = func_rel[PIN_IDX_W+1:2];

    // One select register per pin
    // Pins 0 and 1 come up on the UART slot, the rest on GPIO
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PIN_COUNT; i++) begin
            if (!rst_n) begin
                if (i < 2) begin
                    func_q[i] <= func_sel_t'(`PERI_SLOT_UART);
                end else begin
                    func_q[i] <= func_sel_t'(`PERI_SLOT_GPIO);
                end
            end else if (bus.wr && func_hit && (func_idx == i)) begin
                func_q[i] <= bus.wdata[4:0];
            end
        end
    end

    // Readback of the addressed select code
    always_comb begin
        if (func_hit) begin
            bus.rdata = data_t'(func_q[func_idx]);
        end else begin
            bus.rdata = '0;
        end
    end

    // Per-pin output mux
    // Only the GPIO slot is populated, every other source drives low
    always_comb begin
        for (int i = 0; i < `PIN_COUNT; i++) begin
            if (func_q[i] == func_sel_t'(`PERI_SLOT_GPIO)) begin
                o_uo_out[i] = i_gpio_out[i];
            end else begin
                o_uo_out[i] = 1'b0;
            end
        end
    end

endmodule

// File: design/periph_bus_ctrl.sv
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_bus_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::addr_t     i_addr,
    input  periph_pkg::data_t     i_data,
    input  periph_pkg::acc_size_e i_write_n,
    input  periph_pkg::acc_size_e i_read_n,
    input  logic                  i_read_complete,
    periph_slot_if.ctrl           gpio_bus,
    periph_slot_if.ctrl           func_bus,
    output periph_pkg::data_t     o_data,
    output logic                  o_data_ready
);

    import periph_pkg::*;

    localparam int SLOT_NUM_W = `PERI_ADDR_W - 1 - `PERI_OFS_W;

    logic                  write_req;
    logic                  read_req;
    logic                  byte_win;
    logic [SLOT_NUM_W-1:0] user_slot;
    logic                  gpio_sel;
    data_t                 rd_comb;
    data_t                 data_q;
    logic                  hold_q;
    logic                  ready_q;

    assign write_req = (i_write_n != SZ_NONE);
    assign read_req  = (i_read_n != SZ_NONE);

    // Top address bit selects the byte window, next four the user slot
    assign byte_win  = i_addr[`PERI_ADDR_W-1];
    assign user_slot = i_addr[`PERI_ADDR_W-2:`PERI_OFS_W];
    assign gpio_sel  = !byte_win && (user_slot == SLOT_NUM_W'(`PERI_SLOT_GPIO));

    // Both register blocks live in slot 1 and see the same offset
    assign gpio_bus.ofs   = i_addr[`PERI_OFS_W-1:0];
    assign gpio_bus.wdata = i_data[7:0];
    assign gpio_bus.wr    = write_req && gpio_sel;

    assign func_bus.ofs   = i_addr[`PERI_OFS_W-1:0];
    assign func_bus.wdata = i_data[7:0];
    assign func_bus.wr    = write_req && gpio_sel;

    // Slot read data, each block returns zero off its own registers
    // Empty slots and the byte window read as zero
    assign rd_comb = gpio_sel ? (gpio_bus.rdata | func_bus.rdata) : '0;

    // Hold and ready control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (!hold_q && read_req) begin
                hold_q <= 1'b1;
            end
            // All slots answer at once, so ready just follows the request
            ready_q <= read_req;
        end
    end

    // Read word is captured once and then held until the core takes it
    always_ff @(posedge clk) begin
        if (!hold_q && read_req) begin
            data_q <= rd_comb;
        end
    end

    assign o_data       = data_q;
    assign o_data_ready = ready_q || write_req;

endmodule

// File: design/periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Pins
    input  periph_pkg::byte_t     i_ui_in,
    output periph_pkg::byte_t     o_uo_out,

    // Request from the core
    input  periph_pkg::addr_t     i_addr,
    input  periph_pkg::data_t     i_data,
    input  periph_pkg::acc_size_e i_write_n,
    input  periph_pkg::acc_size_e i_read_n,

    // Read return
    output periph_pkg::data_t     o_data,
    output logic                  o_data_ready,
    input  logic                  i_read_complete
);

    import periph_pkg::*;

    byte_t gpio_out;

    // One link per register block in slot 1
    periph_slot_if gpio_bus ();
    periph_slot_if func_bus ();

    periph_bus_ctrl u_bus_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .gpio_bus        (gpio_bus.ctrl),
        .func_bus        (func_bus.ctrl),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_out_reg u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ui_in    (i_ui_in),
        .bus        (gpio_bus.slot),
        .o_gpio_out (gpio_out)
    );

    // Function selects steer the GPIO byte onto the pins
    pin_func_mux u_pin_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (func_bus.slot),
        .i_gpio_out (gpio_out),
        .o_uo_out   (o_uo_out)
    );

endmodule

// File: verif/tb_periph_top.sv
`timescale 1ns/1ps
`include "periph_defines.svh"

module tb_periph_top;

    import periph_pkg::*;

    localparam int   ROWS        = 44;
    localparam int   CYCLE_LIMIT = 10 * ROWS + 50;
    localparam logic OP_RD       = 1'b0;
    localparam logic OP_WR       = 1'b1;

    logic      clk;
    logic      rst_n;
    byte_t     ui_in;
    byte_t     uo_out;
    addr_t     addr;
    data_t     wdata;
    acc_size_e write_n;
    acc_size_e read_n;
    data_t     rdata;
    logic      data_ready;
    logic      read_complete;

    // Stimulus table
    // The dyn flag marks random write data or a model-derived read value
    logic       row_op   [ROWS];
    logic [1:0] row_sz   [ROWS];
    addr_t      row_addr [ROWS];
    data_t      row_data [ROWS];
    logic       row_dyn  [ROWS];
    data_t      row_exp  [ROWS];
    int         row_cnt;

    // Reference model state
    byte_t     m_gpio;
    func_sel_t m_code [`PIN_COUNT];

    int          errors;
    int          cycles;
    logic [31:0] lfsr;
    data_t       got;
    data_t       exp_val;
    data_t       wval;

    periph_top u_periph_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .i_addr          (addr),
        .i_data          (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .o_data          (rdata),
        .o_data_ready    (data_ready),
        .i_read_complete (read_complete)
    );

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(output data_t val);
        val = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic hits_gpio_slot(input addr_t a);
        return !a[10] && (a[9:6] == 4'(`PERI_SLOT_GPIO));
    endfunction

    function automatic data_t model_read(input addr_t a, input byte_t ui);
        slot_ofs_t ofs;
        ofs = a[5:0];
        if (!hits_gpio_slot(a)) begin
            return '0;
        end
        if (ofs == `GPIO_OFS_OUT) begin
            return {24'b0, m_gpio};
        end else if (ofs == `GPIO_OFS_IN) begin
            return {24'b0, ui};
        end else if (ofs >= `GPIO_OFS_FUNC_BASE && ofs[1:0] == 2'b00) begin
            return {27'b0, m_code[(ofs - `GPIO_OFS_FUNC_BASE) >> 2]};
        end
        return '0;
    endfunction

    task automatic model_write(input addr_t a, input data_t d);
        slot_ofs_t ofs;
        ofs = a[5:0];
        if (hits_gpio_slot(a)) begin
            if (ofs == `GPIO_OFS_OUT) begin
                m_gpio = d[7:0];
            end else if (ofs >= `GPIO_OFS_FUNC_BASE && ofs[1:0] == 2'b00) begin
                m_code[(ofs - `GPIO_OFS_FUNC_BASE) >> 2] = d[4:0];
            end
        end
    endtask

    function automatic byte_t model_pins();
        byte_t p;
        for (int i = 0; i < `PIN_COUNT; i++) begin
            p[i] = (m_code[i] == func_sel_t'(`PERI_SLOT_GPIO)) ? m_gpio[i] : 1'b0;
        end
        return p;
    endfunction

    task automatic set_row(input logic op, input logic [1:0] sz, input addr_t a,
                           input data_t d, input logic dyn, input data_t e);
        row_op[row_cnt]   = op;
        row_sz[row_cnt]   = sz;
        row_addr[row_cnt] = a;
        row_data[row_cnt] = d;
        row_dyn[row_cnt]  = dyn;
        row_exp[row_cnt]  = e;
        row_cnt++;
    endtask

    task automatic bus_write(input logic [1:0] sz, input addr_t a, input data_t d);
        @(negedge clk);
        addr    = a;
        wdata   = d;
        write_n = acc_size_e'(sz);
        #2;
        assert (data_ready === 1'b1) else begin
            errors++;
            $display("CHECK FAILED o_data_ready: got %h expected %h", data_ready, 1'b1);
        end
        @(negedge clk);
        write_n = SZ_NONE;
        wdata   = '0;
    endtask

    task automatic bus_read(input logic [1:0] sz, input addr_t a, input byte_t ui,
                            output data_t val);
        @(negedge clk);
        addr   = a;
        read_n = acc_size_e'(sz);
        ui_in  = ui;
        // Ready only comes back a cycle after the request
        #2;
        assert (data_ready === 1'b0) else begin
            errors++;
            $display("CHECK FAILED o_data_ready: got %h expected %h", data_ready, 1'b0);
        end
        @(negedge clk);
        while (!data_ready) begin
            @(negedge clk);
        end
        val = rdata;
        // Pins move while the word is held
        ui_in = ~ui;
        @(negedge clk);
        assert (rdata === val) else begin
            errors++;
            $display("CHECK FAILED o_data during hold: got %h expected %h", rdata, val);
        end
        assert (data_ready === 1'b1) else begin
            errors++;
            $display("CHECK FAILED o_data_ready: got %h expected %h", data_ready, 1'b1);
        end
        read_n        = SZ_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        assert (data_ready === 1'b0) else begin
            errors++;
            $display("CHECK FAILED o_data_ready: got %h expected %h", data_ready, 1'b0);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = SZ_NONE;
        read_n        = SZ_NONE;
        read_complete = 1'b0;
        errors        = 0;
        cycles        = 0;
        row_cnt       = 0;
        lfsr          = 32'ha19f_0d32;
        m_gpio        = '0;
        for (int i = 0; i < `PIN_COUNT; i++) begin
            m_code[i] = (i < 2) ? func_sel_t'(`PERI_SLOT_UART) : func_sel_t'(`PERI_SLOT_GPIO);
        end

        // Reset values of the function selects
        set_row(OP_RD, SZ_WORD, 11'h060, 32'h0, 1'b0, 32'h2);
        set_row(OP_RD, SZ_WORD, 11'h064, 32'h0, 1'b0, 32'h2);
        set_row(OP_RD, SZ_WORD, 11'h068, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h06C, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h070, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h074, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h078, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h07C, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h040, 32'h0, 1'b0, 32'h0);
        // GPIO output byte through all sizes
        set_row(OP_WR, SZ_BYTE, 11'h040, 32'hFFFF_FFA5, 1'b0, 32'h0);
        set_row(OP_RD, SZ_BYTE, 11'h040, 32'h0, 1'b0, 32'hA5);
        set_row(OP_WR, SZ_HALF, 11'h040, 32'h1234_5C3C, 1'b0, 32'h0);
        set_row(OP_RD, SZ_HALF, 11'h040, 32'h0, 1'b0, 32'h3C);
        set_row(OP_WR, SZ_WORD, 11'h040, 32'h0, 1'b1, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h040, 32'h0, 1'b1, 32'h0);
        // Pin function selects
        set_row(OP_WR, SZ_BYTE, 11'h060, 32'h0000_0001, 1'b0, 32'h0);
        set_row(OP_WR, SZ_WORD, 11'h064, 32'h0000_00E1, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h064, 32'h0, 1'b0, 32'h1);
        set_row(OP_WR, SZ_BYTE, 11'h068, 32'h0000_0010, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h068, 32'h0, 1'b0, 32'h10);
        set_row(OP_WR, SZ_HALF, 11'h07C, 32'h0000_0003, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h07C, 32'h0, 1'b0, 32'h3);
        set_row(OP_WR, SZ_WORD, 11'h070, 32'h0, 1'b1, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h070, 32'h0, 1'b1, 32'h0);
        set_row(OP_WR, SZ_BYTE, 11'h040, 32'h0000_00FF, 1'b0, 32'h0);
        // Input pins with ui_in in the data column
        set_row(OP_RD, SZ_WORD, 11'h044, 32'h5A, 1'b0, 32'h5A);
        set_row(OP_RD, SZ_BYTE, 11'h044, 32'hC3, 1'b0, 32'hC3);
        // Empty slots, byte window and unused offsets
        set_row(OP_RD, SZ_WORD, 11'h000, 32'h0, 1'b0, 32'h0);
        set_row(OP_WR, SZ_WORD, 11'h000, 32'hFFFF_FF00, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h080, 32'h0, 1'b0, 32'h0);
        set_row(OP_WR, SZ_BYTE, 11'h080, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h400, 32'h0, 1'b0, 32'h0);
        set_row(OP_WR, SZ_BYTE, 11'h440, 32'h0, 1'b0, 32'h0);
        set_row(OP_WR, SZ_BYTE, 11'h460, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h4FF, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h440, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h048, 32'h0, 1'b0, 32'h0);
        set_row(OP_WR, SZ_WORD, 11'h048, 32'h01, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h05C, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h062, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h040, 32'h0, 1'b0, 32'hFF);
        set_row(OP_RD, SZ_WORD, 11'h060, 32'h0, 1'b0, 32'h1);
        set_row(OP_RD, SZ_WORD, 11'h3C0, 32'h0, 1'b0, 32'h0);
        set_row(OP_RD, SZ_WORD, 11'h07C, 32'h0, 1'b0, 32'h3);

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #2;
        assert (data_ready === 1'b0) else begin
            errors++;
            $display("CHECK FAILED o_data_ready: got %h expected %h", data_ready, 1'b0);
        end
        assert (uo_out === 8'h00) else begin
            errors++;
            $display("CHECK FAILED o_uo_out: got %h expected %h", uo_out, 8'h00);
        end

        for (int r = 0; r < row_cnt; r++) begin
            if (row_op[r] == OP_WR) begin
                if (row_dyn[r]) begin
                    take_random(wval);
                end else begin
                    wval = row_data[r];
                end
                bus_write(row_sz[r], row_addr[r], wval);
                model_write(row_addr[r], wval);
                assert (uo_out === model_pins()) else begin
                    errors++;
                    $display("CHECK FAILED o_uo_out: got %h expected %h", uo_out, model_pins());
                end
            end else begin
                bus_read(row_sz[r], row_addr[r], row_data[r][7:0], got);
                exp_val = row_dyn[r] ? model_read(row_addr[r], row_data[r][7:0]) : row_exp[r];
                assert (got === exp_val) else begin
                    errors++;
                    $display("CHECK FAILED o_data at %h: got %h expected %h",
                             row_addr[r], got, exp_val);
                end
            end
        end

        $display("Rows run: %0d, errors: %0d", row_cnt, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/periph_pkg.sv
design/periph_slot_if.sv
design/gpio_out_reg.sv
design/pin_func_mux.sv
design/periph_bus_ctrl.sv
design/periph_top.sv
verif/tb_periph_top.sv
